// ==== flist.f ====
hdl/cfg_loader_pkg.sv
hdl/hdr_decode.sv
hdl/frame_exec.sv
hdl/crc_check.sv
hdl/cfg_loader_top.sv
test/cfg_loader_asserts.sv
test/cfg_loader_tb.sv

// ==== test/cfg_loader_tb.sv ====
`timescale 1ns/1ps

module cfg_loader_tb;

    localparam int FRAME_BITS = 64;

    logic clk_i = 1'b0;
    logic rst_i = 1'b0;
    logic data_i = 1'b0;
    logic en_i = 1'b0;
    logic checksum_en_i = 1'b0;
    logic done_ack_i = 1'b0;
    logic prog_data_o;
    logic prog_valid_o;
    logic done_req_o;
    logic crc_ok_o;
    logic hdr_err_o;

    logic        chain_q[$];                        // expected chain bits
    logic [1:0]  status_q[$];                       // expected {crc_ok, hdr_err}
    logic        exp_bit;
    logic [1:0]  exp_status;
    logic        req_prev = 1'b0;
    int          err_cnt = 0;
    int          strobe_cnt = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          test_start_errs = 0;
    int unsigned seed_ret;

    cfg_loader_top #(
        .FRAME_BITS (FRAME_BITS)
    ) UUT (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .data_i        (data_i),
        .en_i          (en_i),
        .checksum_en_i (checksum_en_i),
        .done_ack_i    (done_ack_i),
        .prog_data_o   (prog_data_o),
        .prog_valid_o  (prog_valid_o),
        .done_req_o    (done_req_o),
        .crc_ok_o      (crc_ok_o),
        .hdr_err_o     (hdr_err_o)
    );

    always #2 clk_i = ~clk_i;

    function automatic int used_bits(input int frames, input int last_bits);
        int tail;
        tail = last_bits % FRAME_BITS;
        if (frames == 0)
            return 0;
        return (frames - 1) * FRAME_BITS + ((tail == 0) ? FRAME_BITS : tail);
    endfunction

    function automatic int stream_bits(input int frames, input bit csum);
        return 64 + frames * (FRAME_BITS + (csum ? 8 : 0));
    endfunction

    // x^8+x^2+x+1 with feedback from the top bit
    function automatic logic [7:0] crc_step(input logic [7:0] crc, input logic b);
        logic [7:0] shifted;
        shifted = {crc[6:0], 1'b0};
        return (crc[7] ^ b) ? (shifted ^ 8'h07) : shifted;
    endfunction

    function automatic int total_errors();
        return err_cnt + UUT.u_asserts.fails;
    endfunction

    task automatic drive_bit(input logic b);
        data_i = b;
        en_i   = 1'b1;
        @(negedge clk_i);
    endtask

    // abort_bit of -1 runs the load to the end
    task automatic run_load(input int frames, input int last_bits, input bit csum,
                            input int bad_key, input int abort_bit);
        logic [63:0] hdr;
        logic [63:0] frame;
        logic [7:0]  crc;
        bit          ok;
        int          tail;
        hdr  = {last_bits[31:0], frames[31:0]};
        tail = last_bits % FRAME_BITS;
        ok   = 1'b1;
        checksum_en_i = csum;
        for (int i = 0; i < 64; i++)
            drive_bit(hdr[i]);                      // lsb first
        for (int f = 0; f < frames; f++)
        begin
            frame = {$urandom, $urandom};
            crc   = 8'h00;
            for (int i = 0; i < FRAME_BITS; i++)
            begin
                if (f * FRAME_BITS + i == abort_bit)
                begin
                    en_i = 1'b0;
                    return;
                end
                drive_bit(frame[i]);
                crc = crc_step(crc, frame[i]);
                if (f < frames - 1 || tail == 0 || i < tail)
                    chain_q.push_back(frame[i]);
            end
            if (csum && f == bad_key)
            begin
                crc[3] = ~crc[3];
                ok     = 1'b0;
            end
            if (csum)
                for (int k = 7; k >= 0; k--)
                    drive_bit(crc[k]);              // key msb first
        end
        en_i   = 1'b0;
        data_i = 1'b0;
        status_q.push_back({ok && frames != 0, frames == 0});
    endtask

    task automatic end_test(input string name, input int exp_strobes);
        int waited;
        int errs;
        waited = 0;
        while ((status_q.size() != 0 || chain_q.size() != 0 || done_req_o || done_ack_i)
               && waited < 400)
        begin
            @(negedge clk_i);
            waited++;
        end
        repeat (4) @(negedge clk_i);                // back to idle
        if (waited >= 400)
        begin
            $display("test %s never finished its load and done handshake", name);
            err_cnt++;
        end
        assert (strobe_cnt == exp_strobes)
        else
        begin
            $display("Fail %0t ns: %0d chain strobes, expected %0d", $time, strobe_cnt,
                     exp_strobes);
            err_cnt++;
        end
        errs = total_errors() - test_start_errs;
        tests_run++;
        if (errs != 0)
            tests_failed++;
        $display("test %0d %s: %s", tests_run, name, (errs == 0) ? "ok" : "errors");
        strobe_cnt      = 0;
        test_start_errs = total_errors();
    endtask

    // chain and status monitor
    always @(negedge clk_i)
    begin
        if (rst_i && prog_valid_o)
        begin
            strobe_cnt++;
            exp_bit = (chain_q.size() != 0) ? chain_q.pop_front() : 1'bx;
            assert (prog_data_o === exp_bit)
            else
            begin
                $display("Fail %0t ns: chain bit %b, expected %b", $time, prog_data_o, exp_bit);
                err_cnt++;
            end
        end
        if (rst_i && done_req_o && !req_prev)
        begin
            exp_status = (status_q.size() != 0) ? status_q.pop_front() : 2'bxx;
            assert ({crc_ok_o, hdr_err_o} === exp_status)
            else
            begin
                $display("Fail %0t ns: crc_ok/hdr_err %b%b, expected %b", $time, crc_ok_o,
                         hdr_err_o, exp_status);
                err_cnt++;
            end
        end
        req_prev = done_req_o;
    end

    // host side of the done handshake
    always @(negedge clk_i)
    begin
        if (done_req_o && !done_ack_i)
        begin
            repeat ($urandom_range(1, 5)) @(negedge clk_i);
            done_ack_i = 1'b1;
            while (done_req_o)
                @(negedge clk_i);
            repeat ($urandom_range(1, 3)) @(negedge clk_i);  // ack outlives the request
            done_ack_i = 1'b0;
        end
    end

    initial
    begin
        int limit_ns;
        limit_ns = 2 * 4 * (stream_bits(3, 0) + 2 * stream_bits(3, 1) + 2 * stream_bits(2, 0)
                   + 3 * stream_bits(2, 1) + stream_bits(0, 0)) + 2000;
        #(limit_ns);
        $display("watchdog expired after %0d ns, the run is stuck", limit_ns);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin
        seed_ret = $urandom(32'hc82e8ebe);
        repeat (3) @(negedge clk_i);
        rst_i = 1'b1;
        @(negedge clk_i);
        run_load(3, 0, 1'b0, -1, -1);
        end_test("three frames, no checksum", used_bits(3, 0));
        run_load(3, 0, 1'b1, -1, -1);
        end_test("three frames, good keys", used_bits(3, 0));
        run_load(3, 0, 1'b1, 1, -1);
        end_test("three frames, corrupted key", used_bits(3, 0));
        run_load(2, 5, 1'b0, -1, -1);
        end_test("last frame 5 bits", used_bits(2, 5));
        run_load(2, 17, 1'b1, -1, -1);
        end_test("last frame 17 bits", used_bits(2, 17));
        run_load(2, 0, 1'b0, -1, -1);
        end_test("last frame full", used_bits(2, 0));
        run_load(0, 0, 1'b0, -1, -1);
        end_test("zero frame count", 0);
        run_load(2, 0, 1'b1, -1, FRAME_BITS + 30);  // drop en_i inside frame 1
        repeat (20) @(negedge clk_i);
        run_load(2, 0, 1'b1, -1, -1);
        end_test("aborted load, then good load", FRAME_BITS + 30 + used_bits(2, 0));
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errors());
        if (total_errors() == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== test/cfg_loader_asserts.sv ====
`timescale 1ns/1ps

module cfg_loader_asserts (
    input logic clk_i,
    input logic rst_i,
    input logic done_req_i,
    input logic done_ack_i,
    input logic prog_valid_i,
    input logic prog_data_i,
    input logic crc_ok_i,
    input logic hdr_err_i
);

    int fails = 0;                                  // failed assertion count

    req_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
        done_req_i && !done_ack_i |=> done_req_i)
    else
    begin
        fails++;
        $error("done_req_o fell before done_ack_i was seen high");
    end

    // next request waits for ack low
    req_rise: assert property (@(posedge clk_i) disable iff (!rst_i)
        !done_req_i && done_ack_i |=> !done_req_i)
    else
    begin
        fails++;
        $error("done_req_o rose while done_ack_i was high");
    end

    strobe_vs_req: assert property (@(posedge clk_i) disable iff (!rst_i)
        !(prog_valid_i && done_req_i))
    else
    begin
        fails++;
        $error("prog_valid_o high together with done_req_o");
    end

    no_x_out: assert property (@(posedge clk_i) disable iff (!rst_i)
        !$isunknown({prog_valid_i, prog_data_i, done_req_i, crc_ok_i, hdr_err_i}))
    else
    begin
        fails++;
        $error("unknown value on a loader output");
    end

endmodule

bind cfg_loader_top cfg_loader_asserts u_asserts (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .done_req_i   (done_req_o),
    .done_ack_i   (done_ack_i),
    .prog_valid_i (prog_valid_o),
    .prog_data_i  (prog_data_o),
    .crc_ok_i     (crc_ok_o),
    .hdr_err_i    (hdr_err_o)
);

// ==== hdl/cfg_loader_top.sv ====
`timescale 1ns/1ps

module cfg_loader_top #(
    parameter int FRAME_BITS = 64
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic data_i,
    input  logic en_i,
    input  logic checksum_en_i,
    input  logic done_ack_i,
    output logic prog_data_o,
    output logic prog_valid_o,
    output logic done_req_o,
    output logic crc_ok_o,
    output logic hdr_err_o
);

    logic        hdr_shift;
    logic        hdr_valid;
    logic [31:0] frame_count;
    logic [31:0] last_bits;
    logic        hdr_bad;
    logic        load_start;
    logic        data_bit;
    logic        data_shift;
    logic        key_shift;
    logic        key_last;
    logic        load_end;
    logic        load_bad;
    logic        result_idle;

    hdr_decode #(
        .FRAME_BITS (FRAME_BITS)
    ) u_hdr_decode (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .data_i        (data_i),
        .hdr_shift_i   (hdr_shift),
        .hdr_valid_o   (hdr_valid),
        .frame_count_o (frame_count),
        .last_bits_o   (last_bits),
        .hdr_bad_o     (hdr_bad)
    );

    frame_exec #(
        .FRAME_BITS (FRAME_BITS)
    ) u_frame_exec (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .data_i        (data_i),
        .en_i          (en_i),
        .checksum_en_i (checksum_en_i),
        .hdr_valid_i   (hdr_valid),
        .hdr_bad_i     (hdr_bad),
        .frame_count_i (frame_count),
        .last_bits_i   (last_bits),
        .result_idle_i (result_idle),
        .hdr_shift_o   (hdr_shift),
        .prog_data_o   (prog_data_o),
        .prog_valid_o  (prog_valid_o),
        .load_start_o  (load_start),
        .data_bit_o    (data_bit),
        .data_shift_o  (data_shift),
        .key_shift_o   (key_shift),
        .key_last_o    (key_last),
        .load_end_o    (load_end),
        .load_bad_o    (load_bad)
    );

    crc_check u_crc_check (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .load_start_i  (load_start),
        .data_bit_i    (data_bit),
        .data_shift_i  (data_shift),
        .key_shift_i   (key_shift),
        .key_last_i    (key_last),
        .load_end_i    (load_end),
        .load_bad_i    (load_bad),
        .done_ack_i    (done_ack_i),
        .done_req_o    (done_req_o),
        .crc_ok_o      (crc_ok_o),
        .hdr_err_o     (hdr_err_o),
        .result_idle_o (result_idle)
    );

endmodule

// ==== hdl/crc_check.sv ====
`timescale 1ns/1ps

module crc_check (
    input  logic clk_i,
    input  logic rst_i,
    input  logic load_start_i,
    input  logic data_bit_i,
    input  logic data_shift_i,
    input  logic key_shift_i,
    input  logic key_last_i,
    input  logic load_end_i,
    input  logic load_bad_i,
    input  logic done_ack_i,
    output logic done_req_o,
    output logic crc_ok_o,
    output logic hdr_err_o,
    output logic result_idle_o
);

    localparam int CRC_W = cfg_loader_pkg::CRC_BITS;

    logic [CRC_W-1:0] crc_q;
    logic [CRC_W-1:0] crc_nxt;
    logic [CRC_W-1:0] key_q;
    logic [CRC_W-1:0] key_full;
    logic             crc_fb;
    logic             mismatch_q;                   // sticky over the load
    logic             ack_wait_q;                   // waiting for ack to drop

    assign crc_fb   = crc_q[CRC_W-1] ^ data_bit_i;
    assign crc_nxt  = {crc_q[CRC_W-2:0], 1'b0} ^ (crc_fb ? cfg_loader_pkg::CRC_POLY : '0);
    assign key_full = {key_q[CRC_W-2:0], data_bit_i}; // key msb arrives first

    always_ff @(posedge clk_i)
    begin
        if (!rst_i)
            crc_q <= '0;
        else if (load_start_i || key_last_i)
            crc_q <= '0;                            // new load or next frame
        else if (data_shift_i)
            crc_q <= crc_nxt;
    end

    always_ff @(posedge clk_i)
    begin
        if (key_shift_i)
            key_q <= key_full;
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_i)
            mismatch_q <= 1'b0;
        else if (load_start_i)
            mismatch_q <= 1'b0;
        else if (key_last_i && (key_full != crc_q))
            mismatch_q <= 1'b1;
    end

    // status only moves while no request is open
    always_ff @(posedge clk_i)
    begin
        if (!rst_i)
        begin
            crc_ok_o  <= 1'b0;
            hdr_err_o <= 1'b0;
        end
        else if (load_start_i)
        begin
            crc_ok_o  <= 1'b0;
            hdr_err_o <= 1'b0;
        end
        else if (load_end_i)
        begin
            crc_ok_o  <= !mismatch_q && !load_bad_i;
            hdr_err_o <= load_bad_i;
        end
    end

    // four-phase done handshake
    always_ff @(posedge clk_i)
    begin
        if (!rst_i)
        begin
            done_req_o <= 1'b0;
            ack_wait_q <= 1'b0;
        end
        else if (load_end_i)
        begin
            done_req_o <= 1'b1;
        end
        else if (done_req_o && done_ack_i)
        begin
            done_req_o <= 1'b0;
            ack_wait_q <= 1'b1;
        end
        else if (ack_wait_q && !done_ack_i)
        begin
            ack_wait_q <= 1'b0;
        end
    end

    assign result_idle_o = !done_req_o && !ack_wait_q;

endmodule

// ==== hdl/frame_exec.sv ====
`timescale 1ns/1ps

module frame_exec #(
    parameter int FRAME_BITS = 64
) (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        data_i,
    input  logic        en_i,
    input  logic        checksum_en_i,
    input  logic        hdr_valid_i,
    input  logic        hdr_bad_i,
    input  logic [31:0] frame_count_i,
    input  logic [31:0] last_bits_i,
    input  logic        result_idle_i,
    output logic        hdr_shift_o,
    output logic        prog_data_o,
    output logic        prog_valid_o,
    output logic        load_start_o,
    output logic        data_bit_o,
    output logic        data_shift_o,
    output logic        key_shift_o,
    output logic        key_last_o,
    output logic        load_end_o,
    output logic        load_bad_o
);

    localparam int IDX_W = $clog2(FRAME_BITS);
    localparam logic [IDX_W-1:0] FRAME_LAST = IDX_W'(FRAME_BITS - 1);
    localparam logic [IDX_W-1:0] KEY_LAST = IDX_W'(cfg_loader_pkg::CRC_BITS - 1);

    cfg_loader_pkg::loader_state_e state_q;
    cfg_loader_pkg::loader_state_e state_d;
    logic [IDX_W-1:0] bit_cnt;                      // frame or key bit index
    logic [31:0]      frames_left;                  // includes the current frame
    logic             csum_q;
    logic             hdr_start;
    logic             hdr_reject;
    logic             data_cycle;
    logic             key_cycle;
    logic             last_frame;
    logic             bit_used;
    logic             frame_end;
    logic             key_end;

    // frame bit 0 arrives in the cycle hdr_valid_i is high
    assign hdr_reject = (state_q == cfg_loader_pkg::ST_HEADER) && hdr_valid_i && hdr_bad_i;
    assign hdr_start  = (state_q == cfg_loader_pkg::ST_HEADER) && hdr_valid_i && !hdr_bad_i
                        && en_i;
    assign data_cycle = hdr_start || ((state_q == cfg_loader_pkg::ST_DATA) && en_i);
    assign key_cycle  = (state_q == cfg_loader_pkg::ST_KEY) && en_i;
    assign last_frame = hdr_start ? (frame_count_i == 32'd1) : (frames_left == 32'd1);
    assign bit_used   = !last_frame || (last_bits_i[IDX_W-1:0] == '0)
                        || (bit_cnt < last_bits_i[IDX_W-1:0]);
    assign frame_end  = data_cycle && (bit_cnt == FRAME_LAST);
    assign key_end    = key_cycle && (bit_cnt == KEY_LAST);

    assign hdr_shift_o  = en_i && ((state_q == cfg_loader_pkg::ST_IDLE)
                          || ((state_q == cfg_loader_pkg::ST_HEADER) && !hdr_valid_i));
    assign load_start_o = en_i && (state_q == cfg_loader_pkg::ST_IDLE);
    assign data_bit_o   = data_i;                   // key bits share this line
    assign data_shift_o = data_cycle;
    assign key_shift_o  = key_cycle;
    assign key_last_o   = key_end;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            cfg_loader_pkg::ST_IDLE:
                if (en_i)
                    state_d = cfg_loader_pkg::ST_HEADER;
            cfg_loader_pkg::ST_HEADER:
            begin
                if (hdr_reject)
                    state_d = cfg_loader_pkg::ST_DONE;
                else if (!en_i)
                    state_d = cfg_loader_pkg::ST_IDLE;  // abort
                else if (hdr_valid_i)
                    state_d = cfg_loader_pkg::ST_DATA;
            end
            cfg_loader_pkg::ST_DATA:
            begin
                if (!en_i)
                    state_d = cfg_loader_pkg::ST_IDLE;
                else if (frame_end && csum_q)
                    state_d = cfg_loader_pkg::ST_KEY;
                else if (frame_end && last_frame)
                    state_d = cfg_loader_pkg::ST_DONE;
            end
            cfg_loader_pkg::ST_KEY:
            begin
                if (!en_i)
                    state_d = cfg_loader_pkg::ST_IDLE;
                else if (key_end)
                    state_d = last_frame ? cfg_loader_pkg::ST_DONE : cfg_loader_pkg::ST_DATA;
            end
            cfg_loader_pkg::ST_DONE:
                // load_end_o still high means the request is not raised yet
                if (result_idle_i && !load_end_o)
                    state_d = cfg_loader_pkg::ST_IDLE;
            default:
                state_d = cfg_loader_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_i)
        begin
            state_q     <= cfg_loader_pkg::ST_IDLE;
            bit_cnt     <= '0;
            frames_left <= '0;
            csum_q      <= 1'b0;
            load_end_o  <= 1'b0;
            load_bad_o  <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            if (load_start_o)
                csum_q <= checksum_en_i;            // held for the whole load
            if (hdr_start)
                frames_left <= frame_count_i;
            else if ((frame_end && !csum_q) || key_end)
                frames_left <= frames_left - 32'd1;
            if (key_end || !(data_cycle || key_cycle))
                bit_cnt <= '0;
            else
                bit_cnt <= bit_cnt + 1'b1;          // wraps at frame end
            load_end_o <= hdr_reject || (frame_end && !csum_q && last_frame)
                          || (key_end && last_frame);
            load_bad_o <= hdr_reject;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_i)
        begin
            prog_valid_o <= 1'b0;
            prog_data_o  <= 1'b0;
        end
        else
        begin
            prog_valid_o <= data_cycle && bit_used;
            prog_data_o  <= data_i;
        end
    end

endmodule

// ==== hdl/hdr_decode.sv ====
`timescale 1ns/1ps

module hdr_decode #(
    parameter int FRAME_BITS = 64
) (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        data_i,
    input  logic        hdr_shift_i,
    output logic        hdr_valid_o,
    output logic [31:0] frame_count_o,
    output logic [31:0] last_bits_o,
    output logic        hdr_bad_o
);

    localparam int CNT_W = $clog2(cfg_loader_pkg::HDR_BITS);
    localparam int IDX_W = $clog2(FRAME_BITS);

    cfg_loader_pkg::cfg_header_u hdr_q;
    cfg_loader_pkg::cfg_header_u hdr_nxt;
    logic [CNT_W-1:0]            bit_cnt;
    logic                        hdr_full;

    // lsb arrives first, new bits enter at the top
    assign hdr_nxt.raw = {data_i, hdr_q.raw[cfg_loader_pkg::HDR_BITS-1:1]};
    assign hdr_full = hdr_shift_i && (bit_cnt == CNT_W'(cfg_loader_pkg::HDR_BITS - 1));

    always_ff @(posedge clk_i)
    begin
        if (hdr_shift_i)
            hdr_q <= hdr_nxt;
    end

    // header bits come back to back, a gap restarts the count
    always_ff @(posedge clk_i)
    begin
        if (!rst_i)
            bit_cnt <= '0;
        else if (hdr_shift_i)
            bit_cnt <= bit_cnt + 1'b1;              // wraps after bit 63
        else
            bit_cnt <= '0;
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_i)
        begin
            hdr_valid_o <= 1'b0;
            hdr_bad_o   <= 1'b0;
        end
        else
        begin
            hdr_valid_o <= hdr_full;                // one cycle pulse
            if (hdr_full)
                hdr_bad_o <= (hdr_nxt.fields.frame_count == 32'd0);
        end
    end

    // fields held until the next header completes
    always_ff @(posedge clk_i)
    begin
        if (hdr_full)
        begin
            frame_count_o <= hdr_nxt.fields.frame_count;
            last_bits_o   <= {{(32 - IDX_W){1'b0}}, hdr_nxt.fields.last_bits[IDX_W-1:0]};
        end
    end

endmodule

// ==== hdl/cfg_loader_pkg.sv ====
package cfg_loader_pkg;

    localparam int HDR_BITS = 64;                   // header length
    localparam int CRC_BITS = 8;                    // key length
    localparam logic [CRC_BITS-1:0] CRC_POLY = 8'h07; // x^8+x^2+x+1

    // decoded view of the header word
    typedef struct packed {
        logic [31:0] last_bits;                     // used bits of last frame, 0 = all
        logic [31:0] frame_count;                   // frames in this load
    } cfg_header_s;

    // the same word, raw while shifting and as fields once complete
    typedef union packed {
        logic [HDR_BITS-1:0] raw;
        cfg_header_s         fields;
    } cfg_header_u;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HEADER,
        ST_DATA,
        ST_KEY,
        ST_DONE
    } loader_state_e;

endpackage
